//--- files.f
src/isa_pkg.sv
src/pipe_pkg.sv
src/clock_enable_gen.sv
src/fetch_stage.sv
src/decode_stage.sv
src/execute_stage.sv
src/writeback_stage.sv
src/pipeline_control.sv
src/pipelined_cpu.sv
test/cpu_chk.sv
test/cpu_tb.sv

//--- test/cpu_tb.sv
`timescale 1ns/1ps

module cpu_tb;
    import isa_pkg::*;
    import pipe_pkg::*;

    localparam int NUM_ROWS = 5;
    localparam int HALT_TIMEOUT = 600;
    localparam int HOLD_CYCLES = 20;

    typedef word_t [7:0] prog_t;

    typedef struct packed {
        word_t      divider;
        prog_t      prog;
        logic [7:0] wake_base;
        addr_t      exp_addr;
        word_t      exp_data;
        logic       exp_halt;
    } row_t;

    logic        clk;
    logic        rst_n;
    word_t       clock_divider;
    logic [15:0] interrupts;
    word_t       imem_data;
    addr_t       imem_addr;
    store_req_t  dmem;
    logic        clk_en;
    logic        halted;

    prog_t prog;
    row_t  rows [NUM_ROWS];
    string names [NUM_ROWS];
    string test_name;
    int    seed;
    word_t since_en;
    word_t gap_min;
    word_t gap_max;
    addr_t st_addr_q [$];
    word_t st_data_q [$];

    pipelined_cpu dut_i (
        .clk(clk), .rst_n(rst_n), .clock_divider(clock_divider), .interrupts(interrupts),
        .imem_data(imem_data), .imem_addr(imem_addr), .dmem(dmem), .clk_en(clk_en),
        .halted(halted)
    );

    // Eight program words. Everything above them reads as a nop.
    assign imem_data = (imem_addr < 16'd32) ? prog[imem_addr[4:2]] : '0;

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Records committed stores and the spacing of clk_en pulses.
    always @(posedge clk) begin
        if (!rst_n) begin
            since_en <= '0;
            gap_min <= '1;
            gap_max <= '0;
            st_addr_q.delete();
            st_data_q.delete();
        end else begin
            if (clk_en) begin
                if (since_en != '0 && since_en < gap_min) begin
                    gap_min <= since_en;
                end
                if (since_en != '0 && since_en > gap_max) begin
                    gap_max <= since_en;
                end
                since_en <= 32'd1;
            end else if (since_en != '0) begin
                since_en <= since_en + 32'd1;
            end
            if (clk_en && dmem.we) begin
                st_addr_q.push_back(dmem.addr);
                st_data_q.push_back(dmem.data);
            end
        end
    end

    function automatic word_t encode_instr(
        input opcode_e    op,
        input reg_idx_t   rd,
        input reg_idx_t   rs1,
        input reg_idx_t   rs2,
        input logic [11:0] imm
    );
        word_t w;
        w = '0;
        w[OPC_HI:OPC_LO] = op;
        w[RD_HI:RD_LO] = rd;
        w[RS1_HI:RS1_LO] = rs1;
        w[RS2_HI:RS2_LO] = rs2;
        w[IMM_HI:IMM_LO] = imm;
        return w;
    endfunction

    task automatic abort_run();
        $display(">>> FAIL");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_word(input string what, input word_t exp, input word_t act);
        if (act !== exp) begin
            $display("FAILED %s %s: expected %h, actual %h", test_name, what, exp, act);
            abort_run();
        end
    endtask

    task automatic check_addr(input string what, input addr_t exp, input addr_t act);
        if (act !== exp) begin
            $display("FAILED %s %s: expected %h, actual %h", test_name, what, exp, act);
            abort_run();
        end
    endtask

    task automatic check_flag(input string what, input logic exp, input logic act);
        if (act !== exp) begin
            $display("FAILED %s %s: expected %b, actual %b", test_name, what, exp, act);
            abort_run();
        end
    endtask

    task automatic set_row(
        input int         i,
        input string      name,
        input word_t      divider,
        input prog_t      p,
        input logic [7:0] wake_base,
        input addr_t      exp_addr,
        input word_t      exp_data,
        input logic       exp_halt
    );
        names[i] = name;
        rows[i].divider = divider;
        rows[i].prog = p;
        rows[i].wake_base = wake_base;
        rows[i].exp_addr = exp_addr;
        rows[i].exp_data = exp_data;
        rows[i].exp_halt = exp_halt;
    endtask

    task automatic build_table();
        prog_t p;
        // Back to back dependencies. r3 ends up as 5.
        p = '0;
        p[0] = encode_instr(op_addi, 5'd1, 5'd0, 5'd0, 12'd5);
        p[1] = encode_instr(op_add, 5'd2, 5'd1, 5'd1, 12'd0);
        p[2] = encode_instr(op_sub, 5'd3, 5'd2, 5'd1, 12'd0);
        p[3] = encode_instr(op_store, 5'd0, 5'd0, 5'd3, 12'h010);
        p[4] = encode_instr(op_halt, 5'd0, 5'd0, 5'd0, 12'd0);
        set_row(0, "forwarding", 32'd0, p, 8'd0, 16'h0010, 32'd5, 1'b1);
        set_row(2, "divider", 32'd3, p, 8'd0, 16'h0010, 32'd5, 1'b1);
        // Target is pc+4+8, past both writes of r3.
        p = '0;
        p[0] = encode_instr(op_addi, 5'd3, 5'd0, 5'd0, 12'd7);
        p[1] = encode_instr(op_beqz, 5'd0, 5'd0, 5'd0, 12'd8);
        p[2] = encode_instr(op_addi, 5'd3, 5'd0, 5'd0, 12'd9);
        p[3] = encode_instr(op_addi, 5'd3, 5'd0, 5'd0, 12'd11);
        p[4] = encode_instr(op_store, 5'd0, 5'd0, 5'd3, 12'h020);
        p[5] = encode_instr(op_halt, 5'd0, 5'd0, 5'd0, 12'd0);
        set_row(1, "branch", 32'd0, p, 8'd0, 16'h0020, 32'd7, 1'b1);
        p = '0;
        p[0] = encode_instr(op_addi, 5'd1, 5'd0, 5'd0, 12'd3);
        p[1] = encode_instr(op_store, 5'd0, 5'd0, 5'd1, 12'h030);
        p[2] = encode_instr(op_halt, 5'd0, 5'd0, 5'd0, 12'd0);
        p[3] = encode_instr(op_store, 5'd0, 5'd0, 5'd1, 12'h034);
        p[4] = encode_instr(op_store, 5'd0, 5'd0, 5'd1, 12'h038);
        set_row(3, "halt", 32'd0, p, 8'd0, 16'h0030, 32'd3, 1'b1);
        p = '0;
        p[0] = encode_instr(op_addi, 5'd1, 5'd0, 5'd0, 12'd6);
        p[1] = encode_instr(op_sleep, 5'd0, 5'd0, 5'd0, 12'd0);
        p[2] = encode_instr(op_store, 5'd0, 5'd0, 5'd1, 12'h040);
        p[3] = encode_instr(op_halt, 5'd0, 5'd0, 5'd0, 12'd0);
        set_row(4, "sleep", 32'd1, p, 8'd24, 16'h0040, 32'd6, 1'b1);
    endtask

    task automatic run_row(input int i);
        int cycles;
        int wake;
        test_name = names[i];
        @(posedge clk);
        rst_n <= 1'b0;
        clock_divider <= rows[i].divider;
        interrupts <= '0;
        prog <= rows[i].prog;
        for (int k = 0; k < 3; k++) begin
            @(posedge clk);
        end
        rst_n <= 1'b1;
        if (rows[i].wake_base != '0) begin
            wake = rows[i].wake_base + ($unsigned($random(seed)) % 16);
            for (int k = 0; k < wake; k++) begin
                @(posedge clk);
            end
            @(negedge clk);
            check_word("stores before wake", 32'd0, st_addr_q.size());
            check_flag("halted before wake", 1'b0, halted);
            @(posedge clk);
            interrupts <= 16'h0010;
        end
        cycles = 0;
        while (!halted) begin
            if (cycles == HALT_TIMEOUT) begin
                $display("%s: core did not halt within %0d cycles", test_name, HALT_TIMEOUT);
                abort_run();
            end
            @(posedge clk);
            cycles++;
        end
        for (int k = 0; k < HOLD_CYCLES; k++) begin
            @(posedge clk);
            check_flag("halted stays high", rows[i].exp_halt, halted);
        end
        @(negedge clk);
        check_word("store count", 32'd1, st_addr_q.size());
        check_addr("store address", rows[i].exp_addr, st_addr_q[0]);
        check_word("store data", rows[i].exp_data, st_data_q[0]);
        check_word("clk_en spacing min", rows[i].divider + 32'd1, gap_min);
        check_word("clk_en spacing max", rows[i].divider + 32'd1, gap_max);
    endtask

    initial begin
        rst_n = 1'b0;
        clock_divider = '0;
        interrupts = '0;
        prog = '0;
        seed = 32'h88c5;
        build_table();
        for (int i = 0; i < NUM_ROWS; i++) begin
            run_row(i);
        end
        $display(">>> PASS");
        $finish;
    end

endmodule

//--- test/cpu_chk.sv
`timescale 1ns/1ps

module cpu_chk (
    input logic                 clk,
    input logic                 rst_n,
    input isa_pkg::word_t       clock_divider,
    input pipe_pkg::store_req_t dmem,
    input logic                 clk_en,
    input logic                 halted
);

    // A halted core leaves the data port alone.
    no_store_when_halted: assert property (
        @(posedge clk) disable iff (!rst_n) halted |-> !dmem.we
    ) else $error("store strobe high while the core is halted");

    // With a nonzero divider every pulse is a single cycle.
    single_cycle_enable: assert property (
        @(posedge clk) disable iff (!rst_n) (clock_divider != '0 && clk_en) |=> !clk_en
    ) else $error("clk_en high for two cycles in a row with a nonzero divider");

    // Reset clears the halted state and the store strobe.
    reset_clears_state: assert property (
        @(posedge clk) !rst_n |=> (!halted && !dmem.we)
    ) else $error("halted or store strobe set in the cycle after reset");

endmodule

bind pipelined_cpu cpu_chk chk_i (
    .clk(clk),
    .rst_n(rst_n),
    .clock_divider(clock_divider),
    .dmem(dmem),
    .clk_en(clk_en),
    .halted(halted)
);

//--- src/pipelined_cpu.sv
`timescale 1ns/1ps

module pipelined_cpu (
    input  logic                 clk,
    input  logic                 rst_n,
    input  isa_pkg::word_t       clock_divider,
    input  logic [15:0]          interrupts,
    input  isa_pkg::word_t       imem_data,
    output isa_pkg::addr_t       imem_addr,
    output pipe_pkg::store_req_t dmem,
    output logic                 clk_en,
    output logic                 halted
);
    import isa_pkg::*;
    import pipe_pkg::*;

    decode_pkt_t dec;
    exec_pkt_t   ex;
    wb_pkt_t     wb;
    redirect_t   branch;
    redirect_t   redirect;
    reg_idx_t    rd_idx_a;
    reg_idx_t    rd_idx_b;
    word_t       rd_data_a;
    word_t       rd_data_b;
    logic        halt_seen;
    logic        sleep_seen;
    logic        halt_commit;
    logic        flush;
    logic        frontend_stop;

    clock_enable_gen clk_en_i (
        .clk(clk), .rst_n(rst_n), .clock_divider(clock_divider), .clk_en(clk_en)
    );

    fetch_stage fetch_i (
        .clk(clk), .rst_n(rst_n), .clk_en(clk_en), .frontend_stop(frontend_stop),
        .flush(flush), .redirect(redirect), .imem_data(imem_data),
        .imem_addr(imem_addr), .dec(dec)
    );

    decode_stage decode_i (
        .clk(clk), .rst_n(rst_n), .clk_en(clk_en), .flush(flush), .dec(dec),
        .rd_data_a(rd_data_a), .rd_data_b(rd_data_b),
        .rd_idx_a(rd_idx_a), .rd_idx_b(rd_idx_b), .ex(ex)
    );

    execute_stage execute_i (
        .clk(clk), .rst_n(rst_n), .clk_en(clk_en), .flush(flush), .ex(ex), .wb(wb),
        .branch(branch), .halt_seen(halt_seen), .sleep_seen(sleep_seen)
    );

    writeback_stage writeback_i (
        .clk(clk), .rst_n(rst_n), .clk_en(clk_en), .wb(wb),
        .rd_idx_a(rd_idx_a), .rd_idx_b(rd_idx_b),
        .rd_data_a(rd_data_a), .rd_data_b(rd_data_b),
        .dmem(dmem), .halt_commit(halt_commit)
    );

    pipeline_control control_i (
        .clk(clk), .rst_n(rst_n), .clk_en(clk_en), .branch(branch),
        .halt_seen(halt_seen), .sleep_seen(sleep_seen), .halt_commit(halt_commit),
        .ex_pc(ex.pc), .interrupts(interrupts), .redirect(redirect), .flush(flush),
        .frontend_stop(frontend_stop), .halted(halted)
    );

endmodule

//--- src/pipeline_control.sv
`timescale 1ns/1ps

module pipeline_control (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                clk_en,
    input  pipe_pkg::redirect_t branch,
    input  logic                halt_seen,
    input  logic                sleep_seen,
    input  logic                halt_commit,
    input  isa_pkg::word_t      ex_pc,
    input  logic [15:0]         interrupts,
    output pipe_pkg::redirect_t redirect,
    output logic                flush,
    output logic                frontend_stop,
    output logic                halted
);
    import isa_pkg::*;
    import pipe_pkg::*;

    logic  sleeping;
    word_t sleep_pc;
    logic  wake;

    assign wake = sleeping && interrupts != '0;

    always_comb begin
        if (wake) begin
            redirect.valid = 1'b1;
            redirect.target = sleep_pc;
        end else begin
            redirect = branch;
        end
    end

    // Sleeping and halted keep bubbles in the younger slots.
    assign flush = branch.valid || halt_seen || sleep_seen || sleeping || halted;
    assign frontend_stop = halt_seen || halt_commit || sleep_seen || sleeping || halted;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            halted <= 1'b0;
            sleeping <= 1'b0;
        end else if (clk_en) begin
            if (halt_commit) begin
                halted <= 1'b1;
            end
            if (wake) begin
                sleeping <= 1'b0;
            end else if (sleep_seen) begin
                sleeping <= 1'b1;
            end
        end
    end

    // Resume point is the instruction after the sleep.
    always_ff @(posedge clk) begin
        if (clk_en && sleep_seen) begin
            sleep_pc <= ex_pc + INSTR_BYTES;
        end
    end

endmodule

//--- src/writeback_stage.sv
`timescale 1ns/1ps

module writeback_stage (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 clk_en,
    input  pipe_pkg::wb_pkt_t    wb,
    input  isa_pkg::reg_idx_t    rd_idx_a,
    input  isa_pkg::reg_idx_t    rd_idx_b,
    output isa_pkg::word_t       rd_data_a,
    output isa_pkg::word_t       rd_data_b,
    output pipe_pkg::store_req_t dmem,
    output logic                 halt_commit
);
    import isa_pkg::*;
    import pipe_pkg::*;

    word_t regs [NUM_REGS];
    logic  wr_en;

    assign wr_en = wb.valid && wb.we;

    // r0 reads zero, a write in flight is seen by the reader.
    function automatic word_t read_port(input reg_idx_t idx);
        word_t data;
        if (idx == '0) begin
            data = '0;
        end else if (wr_en && wb.rd == idx) begin
            data = wb.result;
        end else begin
            data = regs[idx];
        end
        return data;
    endfunction

    always_comb begin
        rd_data_a = read_port(rd_idx_a);
        rd_data_b = read_port(rd_idx_b);
    end

    always_ff @(posedge clk) begin
        if (rst_n && clk_en && wr_en) begin
            regs[wb.rd] <= wb.result;
        end
    end

    assign dmem.we = wb.valid && wb.is_store;
    assign dmem.addr = wb.st_addr;
    assign dmem.data = wb.st_data;
    assign halt_commit = wb.valid && wb.is_halt;

endmodule

//--- src/execute_stage.sv
`timescale 1ns/1ps

module execute_stage (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                clk_en,
    input  logic                flush,
    input  pipe_pkg::exec_pkt_t ex,
    output pipe_pkg::wb_pkt_t   wb,
    output pipe_pkg::redirect_t branch,
    output logic                halt_seen,
    output logic                sleep_seen
);
    import isa_pkg::*;
    import pipe_pkg::*;

    word_t   a;
    word_t   b;
    word_t   result;
    word_t   st_sum;
    logic    writes_rd;
    logic    keep;
    wb_pkt_t wb_next;

    // Operands from the record in writeback, older values come from decode.
    assign a = (wb.valid && wb.we && wb.rd == ex.rs1) ? wb.result : ex.a;
    assign b = (wb.valid && wb.we && wb.rd == ex.rs2) ? wb.result : ex.b;

    always_comb begin
        writes_rd = 1'b1;
        case (ex.op)
            op_add: result = a + b;
            op_addi: result = a + ex.imm;
            op_sub: result = a - b;
            default: begin
                result = '0;
                writes_rd = 1'b0;
            end
        endcase
    end

    assign st_sum = a + ex.imm;

    assign branch.valid = ex.valid && ex.op == op_beqz && a == '0;
    assign branch.target = ex.pc + INSTR_BYTES + ex.imm;
    assign halt_seen = ex.valid && ex.op == op_halt;
    assign sleep_seen = ex.valid && ex.op == op_sleep;

    // The flushing instruction is older than its victims, so it still retires.
    assign keep = !flush || branch.valid || halt_seen || sleep_seen;

    always_comb begin
        wb_next.valid = ex.valid && keep;
        wb_next.we = wb_next.valid && writes_rd && ex.rd != '0;
        wb_next.rd = ex.rd;
        wb_next.result = result;
        wb_next.is_store = wb_next.valid && ex.op == op_store;
        wb_next.st_addr = st_sum[ADDR_W-1:0];
        wb_next.st_data = b;
        wb_next.is_halt = wb_next.valid && ex.op == op_halt;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wb <= '0;
        end else if (clk_en) begin
            wb <= wb_next;
        end
    end

endmodule

//--- src/decode_stage.sv
`timescale 1ns/1ps

module decode_stage (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  clk_en,
    input  logic                  flush,
    input  pipe_pkg::decode_pkt_t dec,
    input  isa_pkg::word_t        rd_data_a,
    input  isa_pkg::word_t        rd_data_b,
    output isa_pkg::reg_idx_t     rd_idx_a,
    output isa_pkg::reg_idx_t     rd_idx_b,
    output pipe_pkg::exec_pkt_t   ex
);
    import isa_pkg::*;
    import pipe_pkg::*;

    opcode_e   op_raw;
    opcode_e   op;
    exec_pkt_t ex_next;

    assign op_raw = opcode_e'(dec.instr[OPC_HI:OPC_LO]);
    assign rd_idx_a = dec.instr[RS1_HI:RS1_LO];
    assign rd_idx_b = dec.instr[RS2_HI:RS2_LO];

    // Anything outside the defined opcodes runs as a nop.
    always_comb begin
        case (op_raw)
            op_add,
            op_addi,
            op_sub,
            op_beqz,
            op_store,
            op_sleep,
            op_halt: op = op_raw;
            default: op = op_nop;
        endcase
    end

    always_comb begin
        ex_next.valid = dec.valid && !flush;
        ex_next.op = op;
        ex_next.rd = dec.instr[RD_HI:RD_LO];
        ex_next.rs1 = rd_idx_a;
        ex_next.rs2 = rd_idx_b;
        ex_next.imm = {{(WORD_W-IMM_W){dec.instr[IMM_HI]}}, dec.instr[IMM_HI:IMM_LO]};
        ex_next.pc = dec.pc;
        ex_next.a = rd_data_a;
        ex_next.b = rd_data_b;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ex <= '0;
        end else if (clk_en) begin
            ex <= ex_next;
        end
    end

endmodule

//--- src/fetch_stage.sv
`timescale 1ns/1ps

module fetch_stage (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 clk_en,
    input  logic                 frontend_stop,
    input  logic                 flush,
    input  pipe_pkg::redirect_t  redirect,
    input  isa_pkg::word_t       imem_data,
    output isa_pkg::addr_t       imem_addr,
    output pipe_pkg::decode_pkt_t dec
);
    import isa_pkg::*;
    import pipe_pkg::*;

    word_t pc;

    assign imem_addr = pc[ADDR_W-1:0];

    // Redirect wins over a stop, so a wake can restart a held frontend.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc <= '0;
        end else if (clk_en) begin
            if (redirect.valid) begin
                pc <= redirect.target;
            end else if (!frontend_stop) begin
                pc <= pc + INSTR_BYTES;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            dec <= '0;
        end else if (clk_en) begin
            dec.valid <= !(flush || frontend_stop);
            dec.pc <= pc;
            dec.instr <= imem_data;
        end
    end

endmodule

//--- src/clock_enable_gen.sv
`timescale 1ns/1ps

module clock_enable_gen (
    input  logic           clk,
    input  logic           rst_n,
    input  isa_pkg::word_t clock_divider,
    output logic           clk_en
);
    import isa_pkg::*;

    word_t count;

    // One pulse every clock_divider+1 cycles.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            count <= '0;
            clk_en <= 1'b0;
        end else if (count >= clock_divider) begin
            count <= '0;
            clk_en <= 1'b1;
        end else begin
            count <= count + 1'b1;
            clk_en <= 1'b0;
        end
    end

endmodule

//--- src/pipe_pkg.sv
package pipe_pkg;

    // Fetch to decode.
    typedef struct packed {
        logic           valid;
        isa_pkg::word_t pc;
        isa_pkg::word_t instr;
    } decode_pkt_t;

    // Decode to execute. Immediate is already sign extended.
    typedef struct packed {
        logic              valid;
        isa_pkg::opcode_e  op;
        isa_pkg::reg_idx_t rd;
        isa_pkg::reg_idx_t rs1;
        isa_pkg::reg_idx_t rs2;
        isa_pkg::word_t    imm;
        isa_pkg::word_t    pc;
        isa_pkg::word_t    a;
        isa_pkg::word_t    b;
    } exec_pkt_t;

    // Execute to writeback.
    typedef struct packed {
        logic              valid;
        logic              we;
        isa_pkg::reg_idx_t rd;
        isa_pkg::word_t    result;
        logic              is_store;
        isa_pkg::addr_t    st_addr;
        isa_pkg::word_t    st_data;
        logic              is_halt;
    } wb_pkt_t;

    typedef struct packed {
        logic           valid;
        isa_pkg::word_t target;
    } redirect_t;

    // External data write port.
    typedef struct packed {
        logic           we;
        isa_pkg::addr_t addr;
        isa_pkg::word_t data;
    } store_req_t;

endpackage

//--- src/isa_pkg.sv
package isa_pkg;

    localparam int WORD_W = 32;
    localparam int ADDR_W = 16;
    localparam int REG_W = 5;
    localparam int NUM_REGS = 32;

    typedef logic [WORD_W-1:0] word_t;
    typedef logic [REG_W-1:0] reg_idx_t;
    typedef logic [ADDR_W-1:0] addr_t;

    // Byte distance between two consecutive instructions.
    localparam word_t INSTR_BYTES = 32'd4;

    // Instruction layout: opcode, rd, rs1, rs2, then a signed immediate.
    localparam int OPC_HI = 31;
    localparam int OPC_LO = 27;
    localparam int RD_HI = 26;
    localparam int RD_LO = 22;
    localparam int RS1_HI = 21;
    localparam int RS1_LO = 17;
    localparam int RS2_HI = 16;
    localparam int RS2_LO = 12;
    localparam int IMM_HI = 11;
    localparam int IMM_LO = 0;
    localparam int IMM_W = IMM_HI - IMM_LO + 1;

    typedef enum logic [4:0] {
        op_nop   = 5'd0,
        op_add   = 5'd1,
        op_addi  = 5'd2,
        op_sub   = 5'd3,
        op_beqz  = 5'd4,
        op_store = 5'd5,
        op_sleep = 5'd6,
        op_halt  = 5'd7
    } opcode_e;

endpackage
